//--- filelist.f
source/exec_pkg.sv
source/lead_count.sv
source/trap_unit.sv
source/seq_divider.sv
source/alu.sv
source/exec_stage.sv
test/tb_clock.sv
test/exec_tb.sv

//--- run.sh
#!/bin/sh
# build and run the exec_stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module exec_tb -f filelist.f -o exec_tb_sim

./obj_dir/exec_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

//--- test/exec_tb.sv
`default_nettype none

module exec_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    localparam int reset_cycles = 8;
    localparam int sh_w         = $clog2(data_w);
    localparam int n_basic      = 200;
    localparam int n_hilo       = 10;
    localparam int n_div        = 40;
    localparam int n_misc       = 20;
    // operations issued per group, summed
    localparam int n_ops = 2 + n_basic + 144 + 27 * n_hilo + 3 * n_div + 45
                         + 4 * n_misc + 48;

    logic              clk;
    logic              reset;
    logic              issue;
    logic [op_w-1:0]   op;
    logic [data_w-1:0] src1;
    logic [data_w-1:0] src2;
    logic              ov_check;
    logic              older_exception;
    logic [data_w-1:0] result;
    logic              result_valid;
    logic              overflow;
    logic              trap;
    logic              busy;

    logic [data_w-1:0] hi_m;   // HI/LO model
    logic [data_w-1:0] lo_m;
    int                cycle_count = 0;

    logic [data_w-1:0] exp_res_q[$];
    logic              exp_ovf_q[$];
    logic              exp_trap_q[$];
    int                exp_cyc_q[$];   // -1 for divides
    int                exp_op_q[$];

    int basic_ops[12] = '{op_add, op_sub, op_slt, op_sltu, op_and, op_nor, op_or, op_xor,
                          op_lui, op_sll, op_srl, op_sra};
    int hilo_ops[9]   = '{op_mult, op_multu, op_madd, op_maddu, op_msub, op_msubu,
                          op_mthi, op_mtlo, op_div};
    logic [data_w-1:0] bounds[6] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000,
                                     32'hffff_ffff, 32'h8000_0001};
    // equal, less, greater, then signed and unsigned disagree
    logic [data_w-1:0] trap_a[4] = '{32'd5, 32'd3, 32'd9, 32'hffff_fff0};
    logic [data_w-1:0] trap_b[4] = '{32'd5, 32'd9, 32'd3, 32'h0000_0010};

    tb_clock #(
        .half_period(4)
    ) clock_gen (
        .clk(clk)
    );

    exec_stage #(
        .width(data_w)
    ) UUT (
        .clk             (clk),
        .reset           (reset),
        .issue           (issue),
        .op              (op),
        .src1            (src1),
        .src2            (src2),
        .ov_check        (ov_check),
        .older_exception (older_exception),
        .result          (result),
        .result_valid    (result_valid),
        .overflow        (overflow),
        .trap            (trap),
        .busy            (busy)
    );

    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [data_w-1:0] got, exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic int lead_len(input logic [data_w-1:0] v, input logic ones);
        int n;
        n = 0;
        while (n < data_w && v[data_w-1-n] == ones) begin
            n++;
        end
        return n;
    endfunction

    // expected result and flags from the instruction set rules
    function automatic void ref_model(input int k, input logic [data_w-1:0] a, b,
                                      input logic ovc, output logic [data_w-1:0] res,
                                      output logic ovf, output logic trp);
        res = '0;
        ovf = 1'b0;
        trp = 1'b0;
        case (k)
            op_add: begin
                res = a + b;
                ovf = ovc && (a[data_w-1] == b[data_w-1]) && (res[data_w-1] != a[data_w-1]);
            end
            op_sub: begin
                res = a - b;
                ovf = ovc && (a[data_w-1] != b[data_w-1]) && (res[data_w-1] != a[data_w-1]);
            end
            op_slt:  res = data_w'($signed(a) < $signed(b));
            op_sltu: res = data_w'(a < b);
            op_and:  res = a & b;
            op_nor:  res = ~(a | b);
            op_or:   res = a | b;
            op_xor:  res = a ^ b;
            op_lui:  res = b << (data_w / 2);
            op_sll:  res = b << a[sh_w-1:0];
            op_srl:  res = b >> a[sh_w-1:0];
            op_sra:  res = $signed(b) >>> a[sh_w-1:0];
            op_mfhi: res = hi_m;
            op_mflo: res = lo_m;
            op_clo:  res = data_w'(lead_len(a, 1'b1));
            op_clz:  res = data_w'(lead_len(a, 1'b0));
            op_mul:  res = a * b;   // low word, same for either sign
            op_movn: res = (a != 0) ? b : '0;
            op_movz: res = (a == 0) ? b : '0;
            op_teq, op_teqi:   trp = (a == b);
            op_tne, op_tnei:   trp = (a != b);
            op_tge, op_tgei:   trp = ($signed(a) >= $signed(b));
            op_tgeu, op_tgeiu: trp = (a >= b);
            op_tlt, op_tlti:   trp = ($signed(a) < $signed(b));
            op_tltu, op_tltiu: trp = (a < b);
            default: res = '0;   // divides, multiplies, moves to hi/lo
        endcase
    endfunction

    function automatic void update_hilo(input int k, input logic [data_w-1:0] a, b);
        logic signed [2*data_w-1:0] sa;
        logic signed [2*data_w-1:0] sb;
        logic [2*data_w-1:0]        ua;
        logic [2*data_w-1:0]        ub;
        logic [2*data_w-1:0]        acc;
        sa  = $signed(a);
        sb  = $signed(b);
        ua  = {{data_w{1'b0}}, a};
        ub  = {{data_w{1'b0}}, b};
        acc = {hi_m, lo_m};
        case (k)
            op_mult:  acc = sa * sb;
            op_multu: acc = ua * ub;
            op_madd:  acc = acc + sa * sb;
            op_maddu: acc = acc + ua * ub;
            op_msub:  acc = acc - sa * sb;
            op_msubu: acc = acc - ua * ub;
            op_mthi:  acc[2*data_w-1:data_w] = a;
            op_mtlo:  acc[data_w-1:0] = a;
            op_div:   acc = {data_w'(sa % sb), data_w'(sa / sb)};   // remainder to hi
            op_divu:  acc = {data_w'(ua % ub), data_w'(ua / ub)};
            default:  acc = {hi_m, lo_m};
        endcase
        {hi_m, lo_m} = acc;
    endfunction

    // issue one operation and wait for its result
    task automatic exec_op(input int k, input logic [data_w-1:0] a, b,
                           input logic ovc, input logic blocked);
        logic [data_w-1:0] e_res;
        logic              e_ovf;
        logic              e_trp;
        logic              is_div;
        is_div = (k == op_div) || (k == op_divu);
        ref_model(k, a, b, ovc, e_res, e_ovf, e_trp);
        if (!blocked) begin
            update_hilo(k, a, b);
        end
        exp_res_q.push_back(e_res);
        exp_ovf_q.push_back(e_ovf);
        exp_trap_q.push_back(e_trp);
        exp_cyc_q.push_back(is_div ? -1 : cycle_count + 2);
        exp_op_q.push_back(k);
        issue           = 1'b1;
        op              = '0;
        op[k]           = 1'b1;
        src1            = a;
        src2            = b;
        ov_check        = ovc;
        older_exception = blocked;   // held until the next issue
        @(posedge clk);
        #1;
        issue = 1'b0;
        @(negedge clk);
        while (result_valid !== 1'b1) begin
            if (is_div) begin
                check_flag("busy", busy, 1'b1);
            end
            @(negedge clk);
        end
        if (is_div) begin
            check_flag("busy", busy, 1'b0);
        end
        @(posedge clk);
        #1;
    endtask

    always @(negedge clk) begin : compare
        int k;
        int cyc;
        if (result_valid === 1'b1) begin
            if (exp_res_q.size() == 0) begin
                $display("result_valid pulsed at %0t ns with no operation outstanding", $time);
                abort_run();
            end else begin
                k   = exp_op_q.pop_front();
                cyc = exp_cyc_q.pop_front();
                if (cyc >= 0 && cyc != cycle_count) begin
                    $display("result_valid for op %0d came in cycle %0d instead of %0d",
                             k, cycle_count, cyc);
                    abort_run();
                end
                check_word($sformatf("result (op %0d)", k), result, exp_res_q.pop_front());
                check_flag($sformatf("overflow (op %0d)", k), overflow, exp_ovf_q.pop_front());
                check_flag($sformatf("trap (op %0d)", k), trap, exp_trap_q.pop_front());
            end
        end
    end

    initial begin
        repeat (n_ops * (data_w + 4) + reset_cycles) @(posedge clk);
        $display("watchdog expired, the DUT stopped returning results");
        abort_run();
    end

    initial begin : stimulus
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        int                sh;
        void'($urandom(32'h4f42_6d25));
        reset           = 1'b1;
        issue           = 1'b0;
        op              = '0;
        src1            = '0;
        src2            = '0;
        ov_check        = 1'b0;
        older_exception = 1'b0;
        hi_m            = '0;
        lo_m            = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        // state left behind by reset
        check_flag("result_valid", result_valid, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("overflow", overflow, 1'b0);
        check_flag("trap", trap, 1'b0);
        @(posedge clk);
        #1;

        exec_op(op_mfhi, '0, '0, 1'b0, 1'b0);   // hi/lo cleared by reset
        exec_op(op_mflo, '0, '0, 1'b0, 1'b0);

        repeat (n_basic) begin
            exec_op(basic_ops[$urandom_range(0, 11)], $urandom(), $urandom(),
                    1'($urandom_range(0, 1)), 1'b0);
        end

        foreach (bounds[i]) begin
            foreach (bounds[j]) begin
                for (int m = 0; m < 4; m++) begin
                    exec_op(m[0] ? op_sub : op_add, bounds[i], bounds[j], m[1], 1'b0);
                end
            end
        end

        repeat (n_hilo) begin
            for (int i = 0; i < 8; i++) begin
                exec_op(hilo_ops[i], $urandom(), $urandom(), 1'b0, 1'b0);
                exec_op(op_mfhi, $urandom(), $urandom(), 1'b0, 1'b0);
                exec_op(op_mflo, $urandom(), $urandom(), 1'b0, 1'b0);
            end
            exec_op(op_mul, $urandom(), $urandom(), 1'b0, 1'b0);
            exec_op(op_mfhi, '0, '0, 1'b0, 1'b0);   // mul leaves hi/lo alone
            exec_op(op_mflo, '0, '0, 1'b0, 1'b0);
        end

        for (int r = 0; r < n_div; r++) begin
            a = $urandom();
            case (r % 3)
                0:       b = $urandom();
                1:       b = data_w'($urandom_range(1, 255));
                default: b = ~data_w'($urandom_range(0, 254));   // small negative
            endcase
            if (b == 0) begin
                b = 1;
            end
            exec_op(r[0] ? op_divu : op_div, a, b, 1'b0, 1'b0);
            exec_op(op_mfhi, '0, '0, 1'b0, 1'b0);
            exec_op(op_mflo, '0, '0, 1'b0, 1'b0);
        end

        // writes under an older exception must leave hi/lo alone
        foreach (hilo_ops[i]) begin
            exec_op(op_mthi, $urandom(), '0, 1'b0, 1'b0);
            exec_op(op_mtlo, $urandom(), '0, 1'b0, 1'b0);
            exec_op(hilo_ops[i], $urandom(), data_w'($urandom_range(1, 1000)), 1'b0, 1'b1);
            exec_op(op_mfhi, '0, '0, 1'b0, 1'b0);
            exec_op(op_mflo, '0, '0, 1'b0, 1'b0);
        end

        for (int r = 0; r < n_misc; r++) begin
            sh = $urandom_range(0, data_w);
            a  = data_w'($urandom()) >> sh;   // at least sh leading zeros
            exec_op(op_clz, a, $urandom(), 1'b0, 1'b0);
            exec_op(op_clo, ~a, $urandom(), 1'b0, 1'b0);
            a = r[0] ? data_w'($urandom()) : '0;
            exec_op(op_movn, a, $urandom(), 1'b0, 1'b0);
            exec_op(op_movz, a, $urandom(), 1'b0, 1'b0);
        end

        for (int t = 0; t < 12; t++) begin
            foreach (trap_a[p]) begin
                exec_op(op_teq + t, trap_a[p], trap_b[p], 1'b0, 1'b0);
            end
        end

        repeat (4) @(posedge clk);
        if (exp_res_q.size() != 0) begin
            $display("%0d results never came back from the DUT", exp_res_q.size());
            abort_run();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int half_period = 4   // ns, gives the 8 ns period
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
    end

    always #(half_period) clk = ~clk;

endmodule

`default_nettype wire

//--- source/exec_stage.sv
`default_nettype none

module exec_stage #(
    parameter int width = exec_pkg::data_w
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     issue,
    input  logic [exec_pkg::op_w-1:0] op,
    input  logic [width-1:0]         src1,
    input  logic [width-1:0]         src2,
    input  logic                     ov_check,
    input  logic                     older_exception,
    output logic [width-1:0]         result,
    output logic                     result_valid,
    output logic                     overflow,
    output logic                     trap,
    output logic                     busy
);
    import exec_pkg::*;

    logic [op_w-1:0]  held_op;
    logic [width-1:0] held_src1;
    logic [width-1:0] held_src2;
    logic             held_ov;
    logic             held_valid;   // stays set while a divide runs
    logic [width-1:0] alu_result;
    logic             alu_overflow;
    logic             alu_trap;
    logic             div_pending;
    logic             finish;

    assign finish = held_valid & ~div_pending;
    assign busy   = held_valid & (held_op[op_div] | held_op[op_divu]);

    always_ff @(posedge clk) begin
        if (issue) begin
            held_op   <= op;
            held_src1 <= src1;
            held_src2 <= src2;
            held_ov   <= ov_check;
        end
        if (finish) result <= alu_result;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid   <= 1'b0;
            result_valid <= 1'b0;
            overflow     <= 1'b0;
            trap         <= 1'b0;
        end else begin
            if (issue) begin
                held_valid <= 1'b1;
            end else if (!div_pending) begin
                held_valid <= 1'b0;
            end
            result_valid <= finish;
            if (finish) begin
                overflow <= alu_overflow;
                trap     <= alu_trap;
            end
        end
    end

    alu #(
        .width(width)
    ) u_alu (
        .clk             (clk),
        .reset           (reset),
        .op              (held_op),
        .src1            (held_src1),
        .src2            (held_src2),
        .op_valid        (held_valid),
        .ov_check        (held_ov),
        .older_exception (older_exception),
        .result          (alu_result),
        .overflow        (alu_overflow),
        .trap            (alu_trap),
        .div_pending     (div_pending)
    );

    // environment must wait out a divide
    assert property (@(posedge clk) disable iff (reset) issue |-> !busy);

endmodule

`default_nettype wire

//--- source/alu.sv
`default_nettype none

module alu #(
    parameter int width = exec_pkg::data_w
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [exec_pkg::op_w-1:0] op,
    input  logic [width-1:0]         src1,
    input  logic [width-1:0]         src2,
    input  logic                     op_valid,
    input  logic                     ov_check,
    input  logic                     older_exception,
    output logic [width-1:0]         result,
    output logic                     overflow,
    output logic                     trap,
    output logic                     div_pending
);
    import exec_pkg::*;

    localparam int sh_w = $clog2(width);
    localparam int lc_w = $clog2(width + 1);

    logic                       do_sub;
    logic [width-1:0]           adder_b;
    logic [width-1:0]           sum;
    logic                       carry;
    logic                       slt_bit;
    logic [width-1:0]           sll_result;
    logic [2*width-1:0]         sr_wide;
    logic [width-1:0]           lui_result;
    logic signed [2*width-1:0]  prod_s;
    logic [2*width-1:0]         prod_u;
    logic [lc_w-1:0]            lead;
    logic                       src1_zero;
    hilo_word_t                 hilo_q;
    hilo_word_t                 hilo_next;
    hilo_word_t                 div_word;
    logic                       hilo_op;
    logic                       hilo_we;
    logic                       is_div;
    logic                       div_run;
    logic                       div_start;
    logic                       div_done;
    logic [width-1:0]           quotient;
    logic [width-1:0]           remainder;

    // adder shared by add, sub, slt, sltu
    assign do_sub         = op[op_sub] | op[op_slt] | op[op_sltu];
    assign adder_b        = do_sub ? ~src2 : src2;
    assign {carry, sum}   = src1 + adder_b + {{(width-1){1'b0}}, do_sub};
    assign slt_bit        = (src1[width-1] & ~src2[width-1])
                          | (~(src1[width-1] ^ src2[width-1]) & sum[width-1]);

    // same-sign inputs, sign flipped in the sum
    assign overflow = ov_check & (op[op_add] | op[op_sub])
                    & (src1[width-1] == adder_b[width-1])
                    & (sum[width-1] != src1[width-1]);

    assign sll_result = src2 << src1[sh_w-1:0];
    assign sr_wide    = {{width{op[op_sra] & src2[width-1]}}, src2} >> src1[sh_w-1:0];
    assign lui_result = {src2[width/2-1:0], {(width/2){1'b0}}};

    assign prod_s = $signed(src1) * $signed(src2);
    assign prod_u = src1 * src2;

    assign src1_zero = (src1 == '0);

    lead_count #(
        .width(width)
    ) u_lead_count (
        .value      (src1),
        .count_ones (op[op_clo]),
        .count      (lead)
    );

    trap_unit #(
        .width(width)
    ) u_trap_unit (
        .trap_bits (op[op_tltiu:op_teq]),
        .src1      (src1),
        .src2      (src2),
        .trap      (trap)
    );

    // divider gets one start per held divide
    assign is_div      = op[op_div] | op[op_divu];
    assign div_start   = op_valid & is_div & ~div_run;
    assign div_pending = op_valid & is_div & ~div_done;
    assign div_word    = {quotient, remainder};

    always_ff @(posedge clk) begin
        if (reset) begin
            div_run <= 1'b0;
        end else if (div_start) begin
            div_run <= 1'b1;
        end else if (div_done) begin
            div_run <= 1'b0;
        end
    end

    seq_divider #(
        .width(width)
    ) u_seq_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (op[op_div]),
        .dividend  (src1),
        .divisor   (src2),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    assign hilo_op = op[op_mult] | op[op_multu] | op[op_madd] | op[op_maddu]
                   | op[op_msub] | op[op_msubu] | op[op_mthi] | op[op_mtlo];
    assign hilo_we = op_valid & ~older_exception & (hilo_op | div_done);

    always_comb begin
        hilo_next = hilo_q;
        if (div_done) begin
            hilo_next.product.hi = div_word.div_out.rem;   // remainder to hi
            hilo_next.product.lo = div_word.div_out.quot;
        end else if (op[op_mult]) begin
            hilo_next = prod_s;
        end else if (op[op_multu]) begin
            hilo_next = prod_u;
        end else if (op[op_madd]) begin
            hilo_next = hilo_q + prod_s;
        end else if (op[op_maddu]) begin
            hilo_next = hilo_q + prod_u;
        end else if (op[op_msub]) begin
            hilo_next = hilo_q - prod_s;
        end else if (op[op_msubu]) begin
            hilo_next = hilo_q - prod_u;
        end else if (op[op_mthi]) begin
            hilo_next.product.hi = src1;
        end else if (op[op_mtlo]) begin
            hilo_next.product.lo = src1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hilo_q <= '0;
        end else if (hilo_we) begin
            hilo_q <= hilo_next;
        end
    end

    // trap ops and divides fall through as zero
    assign result = ({width{op[op_add] | op[op_sub]}} & sum)
                  | ({width{op[op_slt]}}  & {{(width-1){1'b0}}, slt_bit})
                  | ({width{op[op_sltu]}} & {{(width-1){1'b0}}, ~carry})
                  | ({width{op[op_and]}}  & (src1 & src2))
                  | ({width{op[op_nor]}}  & ~(src1 | src2))
                  | ({width{op[op_or]}}   & (src1 | src2))
                  | ({width{op[op_xor]}}  & (src1 ^ src2))
                  | ({width{op[op_lui]}}  & lui_result)
                  | ({width{op[op_sll]}}  & sll_result)
                  | ({width{op[op_srl] | op[op_sra]}} & sr_wide[width-1:0])
                  | ({width{op[op_mfhi]}} & hilo_q.product.hi)
                  | ({width{op[op_mflo]}} & hilo_q.product.lo)
                  | ({width{op[op_clo] | op[op_clz]}} & {{(width-lc_w){1'b0}}, lead})
                  | ({width{op[op_mul]}}  & prod_u[width-1:0])
                  | ({width{op[op_movn] & ~src1_zero}} & src2)
                  | ({width{op[op_movz] & src1_zero}}  & src2);

    assert property (@(posedge clk) disable iff (reset) $onehot0(op));

endmodule

`default_nettype wire

//--- source/seq_divider.sv
`default_nettype none

module seq_divider #(
    parameter int width = exec_pkg::data_w
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             is_signed,
    input  logic [width-1:0] dividend,
    input  logic [width-1:0] divisor,
    output logic             done,
    output logic [width-1:0] quotient,
    output logic [width-1:0] remainder
);
    import exec_pkg::*;

    localparam int cnt_w = $clog2(width + 1);

    hilo_word_t       work;       // quot shifts out the dividend, rem is the partial remainder
    logic [width-1:0] dvs_mag;
    logic [cnt_w-1:0] count;
    logic             running;
    logic             neg_quot;
    logic             neg_rem;
    logic [width-1:0] a_mag;
    logic [width-1:0] b_mag;
    logic [width:0]   shifted;
    logic [width+1:0] diff;

    assign a_mag = (is_signed && dividend[width-1]) ? -dividend : dividend;
    assign b_mag = (is_signed && divisor[width-1]) ? -divisor : divisor;

    // next dividend bit into the partial remainder, then trial subtract
    assign shifted = {work.div_out.rem, work.div_out.quot[width-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvs_mag};

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            done    <= 1'b0;
            count   <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                count   <= cnt_w'(width);
            end else if (running) begin
                count <= count - 1'b1;
                if (count == cnt_w'(1)) begin   // last quotient bit this edge
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            work.div_out.quot <= a_mag;
            work.div_out.rem  <= '0;
            dvs_mag           <= b_mag;
            neg_quot          <= is_signed & (dividend[width-1] ^ divisor[width-1]);
            neg_rem           <= is_signed & dividend[width-1];
        end else if (running) begin
            if (!diff[width+1]) begin
                work.div_out.rem  <= diff[width-1:0];
                work.div_out.quot <= {work.div_out.quot[width-2:0], 1'b1};
            end else begin
                work.div_out.rem  <= shifted[width-1:0];   // restore
                work.div_out.quot <= {work.div_out.quot[width-2:0], 1'b0};
            end
        end
    end

    // signs applied on the way out
    assign quotient  = neg_quot ? -work.div_out.quot : work.div_out.quot;
    assign remainder = neg_rem ? -work.div_out.rem : work.div_out.rem;

    assert property (@(posedge clk) disable iff (reset) start |-> !running);
    assert property (@(posedge clk) disable iff (reset) start |-> ##(width + 1) done);

endmodule

`default_nettype wire

//--- source/trap_unit.sv
`default_nettype none

module trap_unit #(
    parameter int width = exec_pkg::data_w
) (
    input  logic [11:0]      trap_bits,
    input  logic [width-1:0] src1,
    input  logic [width-1:0] src2,   // immediate forms arrive already extended
    output logic             trap
);
    import exec_pkg::*;

    trap_kind_e kind;
    logic       is_eq;
    logic       s_less;
    logic       u_less;

    always_comb begin
        case (trap_bits)
            12'b0000_0000_0001: kind = eq;
            12'b0000_0000_0010: kind = eqi;
            12'b0000_0000_0100: kind = ne;
            12'b0000_0000_1000: kind = nei;
            12'b0000_0001_0000: kind = ge;
            12'b0000_0010_0000: kind = gei;
            12'b0000_0100_0000: kind = geu;
            12'b0000_1000_0000: kind = geiu;
            12'b0001_0000_0000: kind = lt;
            12'b0010_0000_0000: kind = lti;
            12'b0100_0000_0000: kind = ltu;
            12'b1000_0000_0000: kind = ltiu;
            default:            kind = none;
        endcase
    end

    assign is_eq  = (src1 == src2);
    assign s_less = ($signed(src1) < $signed(src2));
    assign u_less = (src1 < src2);

    always_comb begin
        case (kind)
            eq, eqi:   trap = is_eq;
            ne, nei:   trap = ~is_eq;
            ge, gei:   trap = ~s_less;
            geu, geiu: trap = ~u_less;
            lt, lti:   trap = s_less;
            ltu, ltiu: trap = u_less;
            default:   trap = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/lead_count.sv
`default_nettype none

module lead_count #(
    parameter int width = exec_pkg::data_w
) (
    input  logic [width-1:0]           value,
    input  logic                       count_ones,   // 1 for clo, 0 for clz
    output logic [$clog2(width+1)-1:0] count
);

    logic stop;

    // scan down from the msb until the first bit that differs
    always_comb begin
        count = '0;
        stop  = 1'b0;
        for (int i = width - 1; i >= 0; i--) begin
            if (!stop && (value[i] == count_ones)) begin
                count = count + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int data_w = 32;
    localparam int op_w   = 41;

    // bit positions in the one-hot operation word
    localparam int op_add   = 0;
    localparam int op_sub   = 1;
    localparam int op_slt   = 2;
    localparam int op_sltu  = 3;
    localparam int op_and   = 4;
    localparam int op_nor   = 5;
    localparam int op_or    = 6;
    localparam int op_xor   = 7;
    localparam int op_sll   = 8;
    localparam int op_srl   = 9;
    localparam int op_sra   = 10;
    localparam int op_lui   = 11;
    localparam int op_div   = 12;
    localparam int op_divu  = 13;
    localparam int op_mult  = 14;
    localparam int op_multu = 15;
    localparam int op_mfhi  = 16;
    localparam int op_mflo  = 17;
    localparam int op_mthi  = 18;
    localparam int op_mtlo  = 19;
    localparam int op_clo   = 20;
    localparam int op_clz   = 21;
    localparam int op_madd  = 22;
    localparam int op_maddu = 23;
    localparam int op_msub  = 24;
    localparam int op_msubu = 25;
    localparam int op_mul   = 26;   // lower product word only, no hi/lo write
    localparam int op_movn  = 27;
    localparam int op_movz  = 28;
    localparam int op_teq   = 29;   // first of the twelve trap bits
    localparam int op_teqi  = 30;
    localparam int op_tne   = 31;
    localparam int op_tnei  = 32;
    localparam int op_tge   = 33;
    localparam int op_tgei  = 34;
    localparam int op_tgeu  = 35;
    localparam int op_tgeiu = 36;
    localparam int op_tlt   = 37;
    localparam int op_tlti  = 38;
    localparam int op_tltu  = 39;
    localparam int op_tltiu = 40;

    typedef enum logic [3:0] {
        none, eq, eqi, ne, nei, ge, gei, geu, geiu, lt, lti, ltu, ltiu
    } trap_kind_e;

    // one 64-bit word, seen as a product or as a divide result
    typedef union packed {
        struct packed {
            logic [data_w-1:0] hi;
            logic [data_w-1:0] lo;
        } product;
        struct packed {
            logic [data_w-1:0] quot;
            logic [data_w-1:0] rem;
        } div_out;
    } hilo_word_t;

endpackage

`default_nettype wire
